// File: include/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Data and address width
`define RV_XLEN 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Architectural registers, x0 included
`define RV_NREGS 32

`endif

// File: hw/rv_pkg.sv
package rv_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_src_e;

    // One view of the instruction word per encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        wb_src_e wb_src;
        logic    branch;
        logic    branch_ne;
        logic    jal;
    } ctrl_s;

endpackage

// File: hw/rv_fwd_if.sv
`timescale 1ns/10ps
`include "rv_config.svh"

interface rv_fwd_if;
    logic [4:0]          rd_mem;
    logic                reg_write_mem;
    logic [`RV_XLEN-1:0] data_mem;
    logic [4:0]          rd_wb;
    logic                reg_write_wb;
    logic [`RV_XLEN-1:0] data_wb;

    // Execute also reads the WB value for its operand muxes
    modport ex_src (output rd_mem, reg_write_mem, data_mem, input data_wb);
    modport wb_src (output rd_wb, reg_write_wb, data_wb);
    modport monitor (input rd_mem, reg_write_mem, data_mem, rd_wb, reg_write_wb, data_wb);
endinterface

// File: hw/rv_fetch.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_if_id,
    input  logic                flush_if_id,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] target_pc,
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] instr_addr,
    output logic [`RV_XLEN-1:0] pc_id,
    output logic [`RV_XLEN-1:0] pc_plus4_id,
    output logic [31:0]         instr_id
);
    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_plus4;

    assign instr_addr = pc;
    assign pc_plus4   = pc + `RV_XLEN'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= `RV_RESET_PC;
        else if (redirect)
            pc <= target_pc;
        else if (!stall_if_id)
            pc <= pc_plus4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            instr_id <= NOP;
        else if (flush_if_id)
            instr_id <= NOP;
        else if (!stall_if_id)
            instr_id <= instr;
    end

    always_ff @(posedge clk) begin
        if (!stall_if_id) begin
            pc_id       <= pc;
            pc_plus4_id <= pc_plus4;
        end
    end
endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2,
    rv_fwd_if.monitor           fwd
);
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];
    logic                wr_en;

    assign wr_en = fwd.reg_write_wb && (fwd.rd_wb != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < `RV_NREGS; k++)
                regs[k] <= '0;
        end else if (wr_en) begin
            regs[fwd.rd_wb] <= fwd.data_wb;
        end
    end

    // Write-before-read bypass with x0 reading as zero
    assign rdata1 = (rs1 == 5'd0) ? '0 :
                    (wr_en && fwd.rd_wb == rs1) ? fwd.data_wb : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 :
                    (wr_en && fwd.rd_wb == rs2) ? fwd.data_wb : regs[rs2];
endmodule

// File: hw/rv_decode.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`RV_XLEN-1:0] pc_id,
    input  logic [`RV_XLEN-1:0] pc_plus4_id,
    input  logic [31:0]         instr_id,
    input  logic                bubble_id_ex,
    input  logic                fwd_br_a,
    input  logic                fwd_br_b,
    rv_fwd_if.monitor           fwd,
    output logic                redirect,
    output logic                branch_taken,
    output logic [`RV_XLEN-1:0] target_pc,
    output logic [4:0]          rs1_id,
    output logic [4:0]          rs2_id,
    output logic                uses_rs1,
    output logic                uses_rs2,
    output logic                is_branch,
    output rv_pkg::ctrl_s       ctrl_ex,
    output logic [4:0]          rs1_ex,
    output logic [4:0]          rs2_ex,
    output logic [4:0]          rd_ex,
    output logic [`RV_XLEN-1:0] op_a_ex,
    output logic [`RV_XLEN-1:0] op_b_ex,
    output logic [`RV_XLEN-1:0] imm_ex,
    output logic [`RV_XLEN-1:0] pc_plus4_ex
);
    import rv_pkg::*;

    instr_u              iw;
    ctrl_s               ctrl;
    logic [`RV_XLEN-1:0] imm, rdata1, rdata2, br_a, br_b;

    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign iw     = instr_id;
    assign rs1_id = iw.r.rs1;
    assign rs2_id = iw.r.rs2;

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (iw.r.opcode)
            OPC_OP: begin
                ctrl.alu_op    = alu_sel(iw.r.funct3, iw.r.funct7[5]);
                ctrl.reg_write = 1'b1;
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            OPC_OP_IMM, OPC_LOAD: begin
                ctrl.alu_op      = (iw.r.opcode == OPC_LOAD) ? ALU_ADD : alu_sel(iw.i.funct3, 1'b0);
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = (iw.r.opcode == OPC_LOAD);
                ctrl.wb_src      = (iw.r.opcode == OPC_LOAD) ? WB_MEM : WB_ALU;
                imm              = {{20{iw.i.imm[11]}}, iw.i.imm};
                uses_rs1         = 1'b1;
            end
            OPC_LUI: begin
                ctrl.alu_op      = ALU_PASSB;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm              = {iw.u.imm, 12'b0};
            end
            OPC_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                imm              = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
                uses_rs1         = 1'b1;
                uses_rs2         = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = iw.b.funct3[0];
                imm            = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11,
                                  iw.b.imm10_5, iw.b.imm4_1, 1'b0};
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
            end
            OPC_JAL: begin
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_src    = WB_PC4;
                imm            = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12,
                                  iw.j.imm11, iw.j.imm10_1, 1'b0};
            end
            default: ;
        endcase
    end

    rv_regfile rv_regfile_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1_id),
        .rs2    (rs2_id),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .fwd    (fwd)
    );

    // WB results already come through the register file bypass
    assign br_a = fwd_br_a ? fwd.data_mem : rdata1;
    assign br_b = fwd_br_b ? fwd.data_mem : rdata2;

    assign is_branch    = ctrl.branch;
    assign branch_taken = ctrl.jal | (ctrl.branch & ((br_a == br_b) ^ ctrl.branch_ne));
    // A stalled branch has stale operands
    assign redirect     = branch_taken & ~bubble_id_ex;
    assign target_pc    = pc_id + imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ctrl_ex <= '0;
        else if (bubble_id_ex)
            ctrl_ex <= '0;
        else
            ctrl_ex <= ctrl;
    end

    always_ff @(posedge clk) begin
        rs1_ex      <= rs1_id;
        rs2_ex      <= rs2_id;
        rd_ex       <= iw.r.rd;
        op_a_ex     <= rdata1;
        op_b_ex     <= rdata2;
        imm_ex      <= imm;
        pc_plus4_ex <= pc_plus4_id;
    end
endmodule

// File: hw/rv_execute.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_execute (
    input  logic                clk,
    input  logic                rst_n,
    input  rv_pkg::ctrl_s       ctrl_ex,
    input  logic [`RV_XLEN-1:0] op_a_ex,
    input  logic [`RV_XLEN-1:0] op_b_ex,
    input  logic [`RV_XLEN-1:0] imm_ex,
    input  logic [`RV_XLEN-1:0] pc_plus4_ex,
    input  logic [4:0]          rd_ex,
    input  logic [1:0]          fwd_a,
    input  logic [1:0]          fwd_b,
    rv_fwd_if.ex_src            fwd_src,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_write_data,
    output logic                ram_write,
    output logic                mem_read_mem,
    output rv_pkg::wb_src_e     wb_src_mem,
    output logic [`RV_XLEN-1:0] pc_plus4_mem
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] src_a, src_b, alu_b, alu_y;
    logic [`RV_XLEN-1:0] alu_q, store_q;
    logic [4:0]          rd_q;
    logic                reg_write_q, mem_write_q;

    // 01 selects MEM, 10 selects WB
    assign src_a = (fwd_a == 2'b01) ? alu_q :
                   (fwd_a == 2'b10) ? fwd_src.data_wb : op_a_ex;
    assign src_b = (fwd_b == 2'b01) ? alu_q :
                   (fwd_b == 2'b10) ? fwd_src.data_wb : op_b_ex;
    assign alu_b = ctrl_ex.alu_src_imm ? imm_ex : src_b;

    always_comb begin
        case (ctrl_ex.alu_op)
            ALU_SUB:   alu_y = src_a - alu_b;
            ALU_AND:   alu_y = src_a & alu_b;
            ALU_OR:    alu_y = src_a | alu_b;
            ALU_XOR:   alu_y = src_a ^ alu_b;
            ALU_SLT:   alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(src_a) < $signed(alu_b)};
            ALU_PASSB: alu_y = alu_b;
            default:   alu_y = src_a + alu_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_write_q  <= 1'b0;
            mem_read_mem <= 1'b0;
            mem_write_q  <= 1'b0;
        end else begin
            reg_write_q  <= ctrl_ex.reg_write;
            mem_read_mem <= ctrl_ex.mem_read;
            mem_write_q  <= ctrl_ex.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        rd_q         <= rd_ex;
        alu_q        <= alu_y;
        store_q      <= src_b;
        wb_src_mem   <= ctrl_ex.wb_src;
        pc_plus4_mem <= pc_plus4_ex;
    end

    assign mem_addr       = alu_q;
    assign mem_write_data = store_q;
    assign ram_write      = mem_write_q;

    assign fwd_src.rd_mem        = rd_q;
    assign fwd_src.reg_write_mem = reg_write_q;
    assign fwd_src.data_mem      = alu_q;
endmodule

// File: hw/rv_memwb.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_memwb (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_read_mem,
    input  rv_pkg::wb_src_e     wb_src_mem,
    input  logic [`RV_XLEN-1:0] pc_plus4_mem,
    input  logic [`RV_XLEN-1:0] mem_read_data,
    rv_fwd_if.monitor           fwd,
    rv_fwd_if.wb_src            fwd_dst
);
    import rv_pkg::*;

    logic                reg_write_q;
    logic [4:0]          rd_q;
    wb_src_e             wb_src_q;
    logic [`RV_XLEN-1:0] alu_q, load_q, pc4_q, wb_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            reg_write_q <= 1'b0;
        else
            reg_write_q <= fwd.reg_write_mem;
    end

    always_ff @(posedge clk) begin
        rd_q     <= fwd.rd_mem;
        wb_src_q <= wb_src_mem;
        alu_q    <= fwd.data_mem;
        pc4_q    <= pc_plus4_mem;
        // Read data is only valid while a load is in MEM
        if (mem_read_mem)
            load_q <= mem_read_data;
    end

    always_comb begin
        case (wb_src_q)
            WB_MEM:  wb_data = load_q;
            WB_PC4:  wb_data = pc4_q;
            default: wb_data = alu_q;
        endcase
    end

    assign fwd_dst.rd_wb        = rd_q;
    assign fwd_dst.reg_write_wb = reg_write_q;
    assign fwd_dst.data_wb      = wb_data;
endmodule

// File: hw/rv_hazard.sv
`timescale 1ns/10ps

module rv_hazard (
    input  logic [4:0]    rs1_id,
    input  logic [4:0]    rs2_id,
    input  logic          uses_rs1,
    input  logic          uses_rs2,
    input  logic          is_branch,
    input  logic          branch_taken,
    input  logic [4:0]    rs1_ex,
    input  logic [4:0]    rs2_ex,
    input  logic [4:0]    rd_ex,
    input  rv_pkg::ctrl_s ctrl_ex,
    input  logic          mem_read_mem,
    rv_fwd_if.monitor     fwd,
    output logic          stall_if_id,
    output logic          flush_if_id,
    output logic          bubble_id_ex,
    output logic [1:0]    fwd_a,
    output logic [1:0]    fwd_b,
    output logic          fwd_br_a,
    output logic          fwd_br_b
);
    logic dep_ex_a, dep_ex_b, dep_mem_a, dep_mem_b;
    logic load_use, branch_stall, stall;

    // x0 never matches
    function automatic logic hit(input logic [4:0] rs, input logic [4:0] rd, input logic we);
        return we && (rs != 5'd0) && (rs == rd);
    endfunction

    assign dep_ex_a  = uses_rs1 && hit(rs1_id, rd_ex, ctrl_ex.reg_write);
    assign dep_ex_b  = uses_rs2 && hit(rs2_id, rd_ex, ctrl_ex.reg_write);
    assign dep_mem_a = uses_rs1 && hit(rs1_id, fwd.rd_mem, fwd.reg_write_mem);
    assign dep_mem_b = uses_rs2 && hit(rs2_id, fwd.rd_mem, fwd.reg_write_mem);

    assign load_use     = ctrl_ex.mem_read && (dep_ex_a || dep_ex_b);
    // A load in MEM only has its address on the forward path
    assign branch_stall = is_branch && (dep_ex_a || dep_ex_b ||
                                        (mem_read_mem && (dep_mem_a || dep_mem_b)));
    assign stall        = load_use || branch_stall;

    assign stall_if_id  = stall;
    assign bubble_id_ex = stall;
    assign flush_if_id  = branch_taken && !stall;

    assign fwd_br_a = dep_mem_a;
    assign fwd_br_b = dep_mem_b;

    // MEM wins over WB
    assign fwd_a = hit(rs1_ex, fwd.rd_mem, fwd.reg_write_mem) ? 2'b01 :
                   hit(rs1_ex, fwd.rd_wb, fwd.reg_write_wb)   ? 2'b10 : 2'b00;
    assign fwd_b = hit(rs2_ex, fwd.rd_mem, fwd.reg_write_mem) ? 2'b01 :
                   hit(rs2_ex, fwd.rd_wb, fwd.reg_write_wb)   ? 2'b10 : 2'b00;
endmodule

// File: hw/rv_pipeline.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_pipeline (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         instr,
    input  logic [`RV_XLEN-1:0] mem_read_data,
    output logic [`RV_XLEN-1:0] instr_addr,
    output logic [`RV_XLEN-1:0] mem_addr,
    output logic [`RV_XLEN-1:0] mem_write_data,
    output logic                ram_write
);
    logic                stall_if_id, flush_if_id, bubble_id_ex;
    logic                redirect, branch_taken;
    logic [`RV_XLEN-1:0] target_pc, pc_id, pc_plus4_id;
    logic [31:0]         instr_id;
    logic                fwd_br_a, fwd_br_b;
    logic [1:0]          fwd_a, fwd_b;
    logic [4:0]          rs1_id, rs2_id, rs1_ex, rs2_ex, rd_ex;
    logic                uses_rs1, uses_rs2, is_branch;
    rv_pkg::ctrl_s       ctrl_ex;
    logic [`RV_XLEN-1:0] op_a_ex, op_b_ex, imm_ex, pc_plus4_ex, pc_plus4_mem;
    logic                mem_read_mem;
    rv_pkg::wb_src_e     wb_src_mem;

    rv_fwd_if fwd_if ();

    rv_fetch rv_fetch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_if_id (stall_if_id),
        .flush_if_id (flush_if_id),
        .redirect    (redirect),
        .target_pc   (target_pc),
        .instr       (instr),
        .instr_addr  (instr_addr),
        .pc_id       (pc_id),
        .pc_plus4_id (pc_plus4_id),
        .instr_id    (instr_id)
    );

    rv_decode rv_decode_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_id        (pc_id),
        .pc_plus4_id  (pc_plus4_id),
        .instr_id     (instr_id),
        .bubble_id_ex (bubble_id_ex),
        .fwd_br_a     (fwd_br_a),
        .fwd_br_b     (fwd_br_b),
        .fwd          (fwd_if),
        .redirect     (redirect),
        .branch_taken (branch_taken),
        .target_pc    (target_pc),
        .rs1_id       (rs1_id),
        .rs2_id       (rs2_id),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .is_branch    (is_branch),
        .ctrl_ex      (ctrl_ex),
        .rs1_ex       (rs1_ex),
        .rs2_ex       (rs2_ex),
        .rd_ex        (rd_ex),
        .op_a_ex      (op_a_ex),
        .op_b_ex      (op_b_ex),
        .imm_ex       (imm_ex),
        .pc_plus4_ex  (pc_plus4_ex)
    );

    rv_execute rv_execute_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_ex        (ctrl_ex),
        .op_a_ex        (op_a_ex),
        .op_b_ex        (op_b_ex),
        .imm_ex         (imm_ex),
        .pc_plus4_ex    (pc_plus4_ex),
        .rd_ex          (rd_ex),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .fwd_src        (fwd_if),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data),
        .ram_write      (ram_write),
        .mem_read_mem   (mem_read_mem),
        .wb_src_mem     (wb_src_mem),
        .pc_plus4_mem   (pc_plus4_mem)
    );

    rv_memwb rv_memwb_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_read_mem  (mem_read_mem),
        .wb_src_mem    (wb_src_mem),
        .pc_plus4_mem  (pc_plus4_mem),
        .mem_read_data (mem_read_data),
        .fwd           (fwd_if),
        .fwd_dst       (fwd_if)
    );

    rv_hazard rv_hazard_inst (
        .rs1_id       (rs1_id),
        .rs2_id       (rs2_id),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .is_branch    (is_branch),
        .branch_taken (branch_taken),
        .rs1_ex       (rs1_ex),
        .rs2_ex       (rs2_ex),
        .rd_ex        (rd_ex),
        .ctrl_ex      (ctrl_ex),
        .mem_read_mem (mem_read_mem),
        .fwd          (fwd_if),
        .stall_if_id  (stall_if_id),
        .flush_if_id  (flush_if_id),
        .bubble_id_ex (bubble_id_ex),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .fwd_br_a     (fwd_br_a),
        .fwd_br_b     (fwd_br_b)
    );
endmodule

// File: tb/tb_rv_pipeline.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module tb_rv_pipeline;
    localparam int PROG_LEN        = 40;
    localparam int EXP_N           = 14;
    localparam int RAM_WORDS       = 64;
    localparam int WATCHDOG_CYCLES = 2 + PROG_LEN * 4 + 50;
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    // Hand-assembled program with word k at address 4*k
    localparam logic [31:0] PROG [0:PROG_LEN-1] = '{
        32'h06400113, // 00 addi x2, x0, 100
        32'hFF900213, // 04 addi x4, x0, -7
        32'h00410333, // 08 add  x6, x2, x4
        32'h40230433, // 0C sub  x8, x6, x2
        32'h08602023, // 10 sw   x6, 0x80(x0)
        32'h08802223, // 14 sw   x8, 0x84(x0)
        32'h00417533, // 18 and  x10, x2, x4
        32'h00416633, // 1C or   x12, x2, x4
        32'h00C54733, // 20 xor  x14, x10, x12
        32'h00222833, // 24 slt  x16, x4, x2
        32'h00412933, // 28 slt  x18, x2, x4
        32'h12345A37, // 2C lui  x20, 0x12345
        32'h678A0A13, // 30 addi x20, x20, 0x678
        32'h08A02423, // 34 sw   x10, 0x88(x0)
        32'h08C02623, // 38 sw   x12, 0x8C(x0)
        32'h08E02823, // 3C sw   x14, 0x90(x0)
        32'h09002A23, // 40 sw   x16, 0x94(x0)
        32'h09202C23, // 44 sw   x18, 0x98(x0)
        32'h09402E23, // 48 sw   x20, 0x9C(x0)
        32'h04002083, // 4C lw   x1, 0x40(x0)
        32'h0A102023, // 50 sw   x1, 0xA0(x0)
        32'h04402183, // 54 lw   x3, 0x44(x0)
        32'h00518B13, // 58 addi x22, x3, 5
        32'h0B602223, // 5C sw   x22, 0xA4(x0)
        32'h00300093, // 60 addi x1, x0, 3
        32'h00009663, // 64 bne  x1, x0, +12
        32'h0A202423, // 68 sw   x2, 0xA8(x0)
        32'h0A202623, // 6C sw   x2, 0xAC(x0)
        32'h00008463, // 70 beq  x1, x0, +8
        32'h0A102423, // 74 sw   x1, 0xA8(x0)
        32'h0A202823, // 78 sw   x2, 0xB0(x0)
        32'h0B002083, // 7C lw   x1, 0xB0(x0)
        32'h00208463, // 80 beq  x1, x2, +8
        32'h0A102A23, // 84 sw   x1, 0xB4(x0)
        32'h00209463, // 88 bne  x1, x2, +8
        32'h0A102A23, // 8C sw   x1, 0xB4(x0)
        32'h008000EF, // 90 jal  x1, +8
        32'h0A202C23, // 94 sw   x2, 0xB8(x0)
        32'h0A102C23, // 98 sw   x1, 0xB8(x0)
        32'h0000006F  // 9C jal  x0, 0
    };

    // Stores in program order
    localparam logic [31:0] EXP_ADDR [0:EXP_N-1] = '{
        32'h80, 32'h84, 32'h88, 32'h8C, 32'h90, 32'h94, 32'h98,
        32'h9C, 32'hA0, 32'hA4, 32'hA8, 32'hB0, 32'hB4, 32'hB8
    };
    localparam logic [31:0] EXP_DATA [0:EXP_N-1] = '{
        32'h0000_005D, // 100 + -7
        32'hFFFF_FFF9, // 93 - 100
        32'h0000_0060, // 0x64 and 0xFFFFFFF9
        32'hFFFF_FFFD,
        32'hFFFF_FF9D,
        32'h0000_0001, // -7 < 100 signed
        32'h0000_0000,
        32'h1234_5678,
        32'h0000_0000, // Plus initial word 16
        32'h0000_0005, // Plus initial word 17
        32'h0000_0003, // Fall-through of beq
        32'h0000_0064,
        32'h0000_0064,
        32'h0000_0094  // Link of jal at 0x90
    };
    // Initial RAM word added to the data column or -1 for none
    localparam int EXP_LOAD [0:EXP_N-1] = '{
        -1, -1, -1, -1, -1, -1, -1, -1, 16, 17, -1, -1, -1, -1
    };

    logic                clk;
    logic                rst_n;
    logic [31:0]         instr;
    logic [`RV_XLEN-1:0] mem_read_data;
    logic [`RV_XLEN-1:0] instr_addr;
    logic [`RV_XLEN-1:0] mem_addr;
    logic [`RV_XLEN-1:0] mem_write_data;
    logic                ram_write;

    logic [31:0] rom [0:PROG_LEN-1];
    logic [31:0] ram [0:RAM_WORDS-1];
    logic [31:0] ram_init [0:RAM_WORDS-1];
    integer      seed;
    int          row = 0;
    logic [31:0] exp_word;

    rv_pipeline rv_pipeline_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (instr),
        .mem_read_data  (mem_read_data),
        .instr_addr     (instr_addr),
        .mem_addr       (mem_addr),
        .mem_write_data (mem_write_data),
        .ram_write      (ram_write)
    );

    // Zero-wait memories that return a nop past the program end
    assign instr = (instr_addr < 32'(PROG_LEN * 4)) ? rom[instr_addr[7:2]] : NOP_WORD;
    assign mem_read_data = ram[mem_addr[7:2]];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < RAM_WORDS; k++)
                ram[k] <= ram_init[k];
        end else if (ram_write) begin
            ram[mem_addr[7:2]] <= mem_write_data;
        end
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic report_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("** Error at %0t ns: store %0d %s 0x%08h, expected 0x%08h",
                 $time, row, what, got, exp);
        abort_run();
    endtask

    function automatic logic [31:0] store_value(input int idx);
        if (EXP_LOAD[idx] < 0)
            return EXP_DATA[idx];
        return EXP_DATA[idx] + ram_init[EXP_LOAD[idx]];
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Every store is checked against the next row of the table
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!ram_write) else begin
                $display("Store request seen while reset is asserted");
                abort_run();
            end
        end else if (ram_write) begin
            assert (row < EXP_N) else begin
                $display("Extra store to 0x%08h after all %0d expected stores",
                         mem_addr, EXP_N);
                abort_run();
            end
            exp_word = store_value(row);
            assert (mem_addr == EXP_ADDR[row])
                else report_value("address", mem_addr, EXP_ADDR[row]);
            assert (mem_write_data == exp_word)
                else report_value("data", mem_write_data, exp_word);
            row = row + 1;
        end
    end

    initial begin
        rst_n = 1'b0;
        seed  = 7807;
        for (int k = 0; k < RAM_WORDS; k++)
            ram_init[k] = $random(seed);
        for (int k = 0; k < PROG_LEN; k++)
            rom[k] = PROG[k];
        repeat (2) @(posedge clk);
        #1;
        assert (instr_addr == `RV_RESET_PC) else begin
            $display("** Error at %0t ns: instr_addr 0x%08h in reset, expected 0x%08h",
                     $time, instr_addr, `RV_RESET_PC);
            abort_run();
        end
        rst_n = 1'b1;
        wait (row == EXP_N);
        // Self-jump must stay quiet
        repeat (20) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d stores seen",
                 WATCHDOG_CYCLES, row, EXP_N);
        abort_run();
    end
endmodule

// File: sim.f
+incdir+include
hw/rv_pkg.sv
hw/rv_fwd_if.sv
hw/rv_fetch.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_memwb.sv
hw/rv_hazard.sv
hw/rv_pipeline.sv
tb/tb_rv_pipeline.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_rv_pipeline
	@out="$$(./obj_dir/Vtb_rv_pipeline)"; echo "$$out"; \
		echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
